// ==== common/fpu_pkg.sv ====
package fpu_pkg;

  typedef logic [31:0]        fp32_t;
  typedef logic [6:0]         funct7_t;
  typedef logic [2:0]         rm_t;
  typedef logic [4:0]         fflags_t;
  typedef logic [1:0]         op_t;
  typedef logic signed [9:0]  exp_t;       // biased, with headroom both ways
  typedef logic [23:0]        mant_t;      // hidden bit included
  typedef logic [27:0]        ext_mant_t;  // carry, 1.23 mantissa, guard, round, sticky

  // accepted funct7 encodings
  localparam funct7_t F7_ADD = 7'b0100000;
  localparam funct7_t F7_SUB = 7'b0100100;
  localparam funct7_t F7_MUL = 7'b0000010;

  localparam op_t OP_ADD = 2'd0;
  localparam op_t OP_SUB = 2'd1;
  localparam op_t OP_MUL = 2'd2;
  localparam op_t OP_BAD = 2'd3;

  localparam rm_t RM_RNE = 3'd0;
  localparam rm_t RM_RTZ = 3'd1;
  localparam rm_t RM_RDN = 3'd2;
  localparam rm_t RM_RUP = 3'd3;
  localparam rm_t RM_RMM = 3'd4;

  // flag bit positions
  localparam int FLAG_NV = 4;
  localparam int FLAG_DZ = 3;
  localparam int FLAG_OF = 2;
  localparam int FLAG_UF = 1;
  localparam int FLAG_NX = 0;

  localparam exp_t  EXP_BIAS  = 10'sd127;
  localparam fp32_t CANON_NAN = 32'h7fc00000;

endpackage

// ==== fpu/fpu_addsub.sv ====
`timescale 1ns/10ps
module fpu_addsub (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                advance,
  input  logic                sign_a,
  input  logic                sign_b,
  input  fpu_pkg::exp_t       exp_a,
  input  fpu_pkg::exp_t       exp_b,
  input  fpu_pkg::mant_t      mant_a,
  input  fpu_pkg::mant_t      mant_b,
  output logic                sum_sign,
  output fpu_pkg::exp_t       sum_exp,
  output fpu_pkg::ext_mant_t  sum_mant
);
  import fpu_pkg::*;

  logic       a_ge_b;
  logic       sign_big;
  exp_t       exp_big, exp_small, diff;
  mant_t      mant_big, mant_small;
  logic [4:0] shamt;
  logic [50:0] wide;      // small mantissa plus room for everything shifted out
  ext_mant_t  big_ext, small_ext, sum_c;

  // larger magnitude goes first, exponents are non-negative here
  assign a_ge_b     = {exp_a, mant_a} >= {exp_b, mant_b};
  assign sign_big   = a_ge_b ? sign_a : sign_b;
  assign exp_big    = a_ge_b ? exp_a : exp_b;
  assign exp_small  = a_ge_b ? exp_b : exp_a;
  assign mant_big   = a_ge_b ? mant_a : mant_b;
  assign mant_small = a_ge_b ? mant_b : mant_a;

  assign diff  = exp_big - exp_small;
  assign shamt = (diff > 10'sd27) ? 5'd27 : diff[4:0]; // beyond 27 all lands in sticky

  assign wide = {mant_small, 27'd0} >> shamt;

  assign big_ext   = {1'b0, mant_big, 3'b000};
  assign small_ext = {1'b0, wide[50:25], wide[24] | (|wide[23:0])};

  // big >= small, so the difference never goes negative
  assign sum_c = (sign_a ^ sign_b) ? big_ext - small_ext
                                   : big_ext + small_ext;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sum_sign <= 1'b0;
      sum_exp  <= '0;
      sum_mant <= '0;
    end else if (advance) begin
      sum_sign <= sign_big;
      sum_exp  <= exp_big;
      sum_mant <= sum_c;    // zero marks exact cancellation
    end
  end

endmodule

// ==== fpu/fpu_issue.sv ====
`timescale 1ns/10ps
module fpu_issue (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              advance,
  input  fpu_pkg::funct7_t  funct7,
  input  fpu_pkg::rm_t      frm,
  input  fpu_pkg::fp32_t    op_a,
  input  fpu_pkg::fp32_t    op_b,
  output fpu_pkg::op_t      op,
  output fpu_pkg::rm_t      rm,
  output logic              sign_a,
  output logic              sign_b,
  output fpu_pkg::exp_t     exp_a,
  output fpu_pkg::exp_t     exp_b,
  output fpu_pkg::mant_t    mant_a,
  output fpu_pkg::mant_t    mant_b,
  output logic              special,
  output fpu_pkg::fp32_t    special_result,
  output fpu_pkg::fflags_t  special_flags
);
  import fpu_pkg::*;

  op_t     op_c;
  rm_t     rm_c;
  logic    a_nan, b_nan, a_snan, b_snan;
  logic    a_inf, b_inf, a_zero, b_zero;
  logic    sb_eff, zero_sign;
  logic    spec_c;
  fp32_t   spec_res_c;
  fflags_t spec_flags_c;

  assign op_c = (funct7 == F7_ADD) ? OP_ADD :
                (funct7 == F7_SUB) ? OP_SUB :
                (funct7 == F7_MUL) ? OP_MUL : OP_BAD;
  assign rm_c = (frm > RM_RMM) ? RM_RNE : frm; // no dynamic rm, treat as RNE

  assign a_nan  = (&op_a[30:23]) & (|op_a[22:0]);
  assign b_nan  = (&op_b[30:23]) & (|op_b[22:0]);
  assign a_snan = a_nan & ~op_a[22];
  assign b_snan = b_nan & ~op_b[22];
  assign a_inf  = (&op_a[30:23]) & ~(|op_a[22:0]);
  assign b_inf  = (&op_b[30:23]) & ~(|op_b[22:0]);
  assign a_zero = ~(|op_a[30:23]); // subnormals count as zero
  assign b_zero = ~(|op_b[30:23]);

  assign sb_eff    = op_b[31] ^ (op_c == OP_SUB);
  // like signs keep their sign, unlike signs give +0 or -0 under RDN
  assign zero_sign = (op_a[31] & sb_eff) | ((op_a[31] ^ sb_eff) & (rm_c == RM_RDN));

  always_comb begin
    spec_c       = 1'b1;
    spec_res_c   = CANON_NAN;
    spec_flags_c = '0;
    if (op_c == OP_BAD) begin
      spec_flags_c[FLAG_NV] = 1'b1;
    end else if (a_nan | b_nan) begin
      spec_flags_c[FLAG_NV] = a_snan | b_snan; // quiet NaN propagates silently
    end else if (op_c == OP_MUL) begin
      if ((a_inf & b_zero) | (b_inf & a_zero)) begin
        spec_flags_c[FLAG_NV] = 1'b1;
      end else if (a_inf | b_inf) begin
        spec_res_c = {op_a[31] ^ op_b[31], 8'hff, 23'd0};
      end else if (a_zero | b_zero) begin
        spec_res_c = {op_a[31] ^ op_b[31], 31'd0};
      end else begin
        spec_c = 1'b0;
      end
    end else begin
      if (a_inf & b_inf & (op_a[31] != sb_eff)) begin
        spec_flags_c[FLAG_NV] = 1'b1; // inf - inf
      end else if (a_inf) begin
        spec_res_c = {op_a[31], 8'hff, 23'd0};
      end else if (b_inf) begin
        spec_res_c = {sb_eff, 8'hff, 23'd0};
      end else if (a_zero & b_zero) begin
        spec_res_c = {zero_sign, 31'd0};
      end else begin
        spec_c = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op             <= OP_ADD;
      rm             <= RM_RNE;
      sign_a         <= 1'b0;
      sign_b         <= 1'b0;
      exp_a          <= '0;
      exp_b          <= '0;
      mant_a         <= '0;
      mant_b         <= '0;
      special        <= 1'b0;
      special_result <= '0;
      special_flags  <= '0;
    end else if (advance) begin
      op             <= op_c;
      rm             <= rm_c;
      sign_a         <= op_a[31];
      sign_b         <= sb_eff;
      exp_a          <= a_zero ? exp_t'(0) : exp_t'({2'b00, op_a[30:23]});
      exp_b          <= b_zero ? exp_t'(0) : exp_t'({2'b00, op_b[30:23]});
      mant_a         <= a_zero ? mant_t'(0) : {1'b1, op_a[22:0]}; // hidden bit back
      mant_b         <= b_zero ? mant_t'(0) : {1'b1, op_b[22:0]};
      special        <= spec_c;
      special_result <= spec_res_c;
      special_flags  <= spec_flags_c;
    end
  end

endmodule

// ==== fpu/fpu_mul.sv ====
`timescale 1ns/10ps
module fpu_mul (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                advance,
  input  logic                sign_a,
  input  logic                sign_b,
  input  fpu_pkg::exp_t       exp_a,
  input  fpu_pkg::exp_t       exp_b,
  input  fpu_pkg::mant_t      mant_a,
  input  fpu_pkg::mant_t      mant_b,
  output logic                prod_sign,
  output fpu_pkg::exp_t       prod_exp,
  output fpu_pkg::ext_mant_t  prod_mant
);
  import fpu_pkg::*;

  logic [47:0] prod; // 2.46 fixed point
  ext_mant_t   prod_ext;

  assign prod = mant_a * mant_b;

  // bit 47 is the carry, 46 the hidden bit, then 23 fraction bits, g, r, sticky
  assign prod_ext = {prod[47:21], |prod[20:0]};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_sign <= 1'b0;
      prod_exp  <= '0;
      prod_mant <= '0;
    end else if (advance) begin
      prod_sign <= sign_a ^ sign_b;
      prod_exp  <= exp_a + exp_b - EXP_BIAS; // still biased once
      prod_mant <= prod_ext;
    end
  end

endmodule

// ==== fpu/fpu_round.sv ====
`timescale 1ns/10ps
module fpu_round (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                advance,
  input  fpu_pkg::op_t        op,
  input  fpu_pkg::rm_t        rm,
  input  logic                sum_sign,
  input  fpu_pkg::exp_t       sum_exp,
  input  fpu_pkg::ext_mant_t  sum_mant,
  input  logic                prod_sign,
  input  fpu_pkg::exp_t       prod_exp,
  input  fpu_pkg::ext_mant_t  prod_mant,
  input  logic                special,
  input  fpu_pkg::fp32_t      special_result,
  input  fpu_pkg::fflags_t    special_flags,
  output fpu_pkg::fp32_t      result,
  output fpu_pkg::fflags_t    flags
);
  import fpu_pkg::*;

  // stage 2 copies, aligned with the datapath registers
  op_t       op_q;
  rm_t       rm_q;
  logic      spec_q;
  fp32_t     spec_res_q;
  fflags_t   spec_flags_q;

  logic        sel_sign;
  exp_t        sel_exp, norm_exp, exp_r;
  ext_mant_t   m;
  logic [4:0]  lz;
  logic [26:0] norm;    // hidden bit at 26, then fraction, round at 2
  logic        rbit, stk, inexact, round_up, to_inf;
  logic [24:0] mant_r;
  fp32_t       res_c;
  fflags_t     flags_c;

  assign sel_sign = (op_q == OP_MUL) ? prod_sign : sum_sign;
  assign sel_exp  = (op_q == OP_MUL) ? prod_exp : sum_exp;
  assign m        = (op_q == OP_MUL) ? prod_mant : sum_mant;

  always_comb begin
    lz = 5'd0;
    for (int i = 0; i < 27; i++) begin
      if (m[i]) lz = 5'(26 - i); // highest set bit wins
    end
    if (m[27]) begin
      norm     = {m[27:2], m[1] | m[0]};
      norm_exp = sel_exp + 10'sd1;
    end else begin
      norm     = m[26:0] << lz;
      norm_exp = sel_exp - exp_t'(lz);
    end
  end

  assign rbit    = norm[2];
  assign stk     = |norm[1:0];
  assign inexact = rbit | stk;

  always_comb begin
    case (rm_q)
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = inexact & sel_sign;
      RM_RUP:  round_up = inexact & ~sel_sign;
      RM_RMM:  round_up = rbit;
      default: round_up = rbit & (stk | norm[3]); // ties to even
    endcase
  end

  assign mant_r = {1'b0, norm[26:3]} + 25'(round_up);
  assign exp_r  = norm_exp + exp_t'(mant_r[24]); // mantissa overflow bumps exponent

  assign to_inf = (rm_q == RM_RNE) | (rm_q == RM_RMM) |
                  ((rm_q == RM_RUP) & ~sel_sign) | ((rm_q == RM_RDN) & sel_sign);

  always_comb begin
    flags_c = '0;
    if (spec_q) begin
      res_c   = spec_res_q;
      flags_c = spec_flags_q;
    end else if (m == '0) begin
      res_c = {rm_q == RM_RDN, 31'd0}; // exact cancellation
    end else if (exp_r >= 10'sd255) begin
      res_c            = to_inf ? {sel_sign, 8'hff, 23'd0} : {sel_sign, 31'h7f7fffff};
      flags_c[FLAG_OF] = 1'b1;
      flags_c[FLAG_NX] = 1'b1;
    end else if (exp_r <= 10'sd0) begin
      res_c            = {sel_sign, 31'd0}; // flush to zero
      flags_c[FLAG_UF] = 1'b1;
      flags_c[FLAG_NX] = 1'b1;
    end else begin
      res_c            = {sel_sign, exp_r[7:0], mant_r[22:0]};
      flags_c[FLAG_NX] = inexact;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_q         <= OP_ADD;
      rm_q         <= RM_RNE;
      spec_q       <= 1'b0;
      spec_res_q   <= '0;
      spec_flags_q <= '0;
      result       <= '0;
      flags        <= '0;
    end else if (advance) begin
      op_q         <= op;
      rm_q         <= rm;
      spec_q       <= special;
      spec_res_q   <= special_result;
      spec_flags_q <= special_flags;
      result       <= res_c;
      flags        <= flags_c;
    end
  end

endmodule

// ==== fpu/fpu_top.sv ====
`timescale 1ns/10ps
module fpu_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  output logic              in_ready,
  input  fpu_pkg::funct7_t  funct7,
  input  fpu_pkg::rm_t      frm,
  input  fpu_pkg::fp32_t    op_a,
  input  fpu_pkg::fp32_t    op_b,
  output logic              out_valid,
  input  logic              out_ready,
  output fpu_pkg::fp32_t    result,
  output fpu_pkg::fflags_t  flags
);
  import fpu_pkg::*;

  logic      advance;

  // stage 1 outputs
  op_t       op;
  rm_t       rm;
  logic      sign_a, sign_b;
  exp_t      exp_a, exp_b;
  mant_t     mant_a, mant_b;
  logic      special;
  fp32_t     special_result;
  fflags_t   special_flags;

  // stage 2 outputs
  logic      sum_sign, prod_sign;
  exp_t      sum_exp, prod_exp;
  ext_mant_t sum_mant, prod_mant;

  fpu_pipe_ctrl i_ctrl (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .out_ready(out_ready),
    .advance(advance), .in_ready(in_ready), .out_valid(out_valid)
  );

  fpu_issue i_issue (
    .clk(clk), .arst_n(arst_n), .advance(advance),
    .funct7(funct7), .frm(frm), .op_a(op_a), .op_b(op_b),
    .op(op), .rm(rm), .sign_a(sign_a), .sign_b(sign_b),
    .exp_a(exp_a), .exp_b(exp_b), .mant_a(mant_a), .mant_b(mant_b),
    .special(special), .special_result(special_result), .special_flags(special_flags)
  );

  fpu_addsub i_addsub (
    .clk(clk), .arst_n(arst_n), .advance(advance),
    .sign_a(sign_a), .sign_b(sign_b), .exp_a(exp_a), .exp_b(exp_b),
    .mant_a(mant_a), .mant_b(mant_b),
    .sum_sign(sum_sign), .sum_exp(sum_exp), .sum_mant(sum_mant)
  );

  fpu_mul i_mul (
    .clk(clk), .arst_n(arst_n), .advance(advance),
    .sign_a(sign_a), .sign_b(sign_b), .exp_a(exp_a), .exp_b(exp_b),
    .mant_a(mant_a), .mant_b(mant_b),
    .prod_sign(prod_sign), .prod_exp(prod_exp), .prod_mant(prod_mant)
  );

  fpu_round i_round (
    .clk(clk), .arst_n(arst_n), .advance(advance), .op(op), .rm(rm),
    .sum_sign(sum_sign), .sum_exp(sum_exp), .sum_mant(sum_mant),
    .prod_sign(prod_sign), .prod_exp(prod_exp), .prod_mant(prod_mant),
    .special(special), .special_result(special_result), .special_flags(special_flags),
    .result(result), .flags(flags)
  );

endmodule

// ==== logic/fpu_pipe_ctrl.sv ====
`timescale 1ns/10ps
module fpu_pipe_ctrl (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  logic out_ready,
  output logic advance,
  output logic in_ready,
  output logic out_valid
);

  logic [2:0] vld; // one bit per stage, [2] is the output register

  // whole pipe freezes only while a result is stalled at the output
  assign advance   = ~(vld[2] & ~out_ready);
  assign in_ready  = advance;
  assign out_valid = vld[2];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vld <= 3'b000;
    end else if (advance) begin
      vld <= {vld[1:0], in_valid};
    end
  end

endmodule

// ==== sim.f ====
common/fpu_pkg.sv
logic/fpu_pipe_ctrl.sv
fpu/fpu_issue.sv
fpu/fpu_addsub.sv
fpu/fpu_mul.sv
fpu/fpu_round.sv
fpu/fpu_top.sv
tb/fpu_top_asserts.sv
tb/tb_fpu_top.sv

// ==== tb/fpu_input.txt ====
// columns: funct7 rm operand_a operand_b expected_result expected_flags
// funct7 20 add, 24 sub, 02 mul; flags are NV DZ OF UF NX from bit 4 down
20 0 3f800000 40000000 40400000 00
24 0 40400000 3f800000 40000000 00
02 0 3fc00000 40800000 40c00000 00
20 0 bf800000 c0000000 c0400000 00
02 0 c0000000 40400000 c0c00000 00
02 0 3fc00000 3fc00000 40100000 00
20 0 3fc00000 bfc00000 00000000 00
24 2 3fc00000 3fc00000 80000000 00
20 0 80000000 80000000 80000000 00
20 0 3f800000 33800000 3f800000 01
20 3 3f800000 33800000 3f800001 01
20 4 3f800000 33800000 3f800001 01
20 0 3f800001 33800000 3f800002 01
20 0 3f800000 33c00000 3f800001 01
20 1 3f800000 33c00000 3f800000 01
20 2 bf800000 b3c00000 bf800001 01
20 3 bf800000 b3c00000 bf800000 01
20 6 3f800000 33c00000 3f800001 01
02 0 3fc00000 3f800001 3fc00002 01
02 1 3fc00000 3f800001 3fc00001 01
24 0 3f800000 33000000 3f800000 01
24 1 3f800000 33000000 3f7fffff 01
02 0 7f000000 40000000 7f800000 05
02 1 7f000000 40000000 7f7fffff 05
20 2 ff7fffff ff7fffff ff800000 05
20 3 ff7fffff ff7fffff ff7fffff 05
02 0 80800000 3f000000 80000000 03
24 0 00800001 00800000 00000000 03
20 0 00000001 3f800000 3f800000 00
02 0 80400000 40000000 80000000 00
20 0 7fc00001 3f800000 7fc00000 00
02 0 7f800001 3f800000 7fc00000 10
24 0 7f800000 7f800000 7fc00000 10
02 0 00000000 ff800000 7fc00000 10
01 0 3f800000 3f800000 7fc00000 10
20 0 7f800000 3f800000 7f800000 00

// ==== tb/fpu_top_asserts.sv ====
`timescale 1ns/10ps
module fpu_top_asserts (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_ready,
  input  logic              out_valid,
  input  logic              out_ready,
  input  fpu_pkg::fp32_t    result,
  input  fpu_pkg::fflags_t  flags
);

  int fail_cnt = 0; // read by the testbench at the end

  reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else begin
      fail_cnt++;
      $error("out_valid high while reset is asserted");
    end

  // first edge after release and the one after it
  release_quiet: assert property (@(posedge clk) $rose(arst_n) |-> !out_valid ##1 !out_valid)
    else begin
      fail_cnt++;
      $error("out_valid high right after reset release");
    end

  stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
      out_valid && !out_ready |=> out_valid && $stable(result) && $stable(flags))
    else begin
      fail_cnt++;
      $error("output changed while stalled");
    end

  ready_low: assert property (@(posedge clk) disable iff (!arst_n)
      !in_ready |-> out_valid && !out_ready)
    else begin
      fail_cnt++;
      $error("in_ready low without output back-pressure");
    end

endmodule

// ==== tb/tb_fpu_top.sv ====
`timescale 1ns/10ps
module tb_fpu_top;
  import fpu_pkg::*;

  localparam int NUM_VEC   = 36;
  localparam int WORDS     = 6;                 // funct7, rm, a, b, result, flags
  localparam int WD_CYCLES = NUM_VEC * 20 * 2;  // two passes over the vector set

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  logic    in_ready;
  funct7_t funct7;
  rm_t     frm;
  fp32_t   op_a;
  fp32_t   op_b;
  logic    out_valid;
  logic    out_ready;
  fp32_t   result;
  fflags_t flags;

  logic [31:0] vec_mem [NUM_VEC*WORDS];
  logic [31:0] lfsr;
  int          cur_idx;   // vector currently on the input port
  int          cycle;
  int          pass_no;
  int          err_result, err_flags, err_latency, err_proto;
  int          idx_q[$];
  int          acc_cyc_q[$];

  fpu_top i_dut (
    .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
    .funct7(funct7), .frm(frm), .op_a(op_a), .op_b(op_b),
    .out_valid(out_valid), .out_ready(out_ready), .result(result), .flags(flags)
  );

  bind fpu_top fpu_top_asserts i_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr_bit()};
    end
    return v;
  endfunction

  task automatic check_result(input fp32_t got, input fp32_t exp, input int vec);
    if (got !== exp) begin
      err_result++;
      $display("[FAIL] %0t: vector %0d result %h, expected %h", $time, vec, got, exp);
    end
  endtask

  task automatic check_flags(input fflags_t got, input fflags_t exp, input int vec);
    if (got !== exp) begin
      err_flags++;
      $display("[FAIL] %0t: vector %0d flags %b, expected %b", $time, vec, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp, input int vec);
    if (got != exp) begin
      err_latency++;
      $display("[FAIL] %0t: vector %0d latency %0d, expected %0d", $time, vec, got, exp);
    end
  endtask

  task automatic present(input int idx);
    funct7   = funct7_t'(vec_mem[idx*WORDS]);
    frm      = rm_t'(vec_mem[idx*WORDS+1]);
    op_a     = vec_mem[idx*WORDS+2];
    op_b     = vec_mem[idx*WORDS+3];
    cur_idx  = idx;
    in_valid = 1'b1;
  endtask

  // pass 0 streams back to back, pass 1 adds input gaps and stalls
  task automatic run_pass(input int pass);
    int   idx;
    logic took;
    idx     = 0;
    took    = 1'b0;
    pass_no = pass;
    while (idx < NUM_VEC) begin
      @(posedge clk);
      #1;
      out_ready = (pass == 0) ? 1'b1 : (rand_bits(2) != 0);
      if (took) in_valid = 1'b0;
      if (!in_valid && (pass == 0 || rand_bits(2) != 0)) present(idx);
      @(negedge clk);
      took = in_valid & in_ready;
      if (took) idx++;
    end
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    while (idx_q.size() != 0) begin
      @(posedge clk);
      #1;
      out_ready = (pass == 0) ? 1'b1 : (rand_bits(1) != 0);
    end
  endtask

  always @(negedge clk) begin : monitor
    int idx;
    int acc;
    if (arst_n && in_valid && in_ready) begin
      idx_q.push_back(cur_idx);
      acc_cyc_q.push_back(cycle);
    end
    if (arst_n && out_valid && out_ready) begin
      if (idx_q.size() == 0) begin
        err_proto++;
        $display("a result came out with no input waiting for it at %0t", $time);
      end else begin
        idx = idx_q.pop_front();
        acc = acc_cyc_q.pop_front();
        check_result(result, vec_mem[idx*WORDS+4], idx);
        check_flags(flags, fflags_t'(vec_mem[idx*WORDS+5]), idx);
        if (pass_no == 0) check_latency(cycle - acc, 3, idx);
      end
    end
  end

  initial begin
    lfsr      = 32'h477c;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    funct7    = '0;
    frm       = '0;
    op_a      = '0;
    op_b      = '0;
    out_ready = 1'b1;
    cur_idx   = 0;
    cycle     = 0;
    pass_no   = 0;
    err_result  = 0;
    err_flags   = 0;
    err_latency = 0;
    err_proto   = 0;
    $readmemh("tb/fpu_input.txt", vec_mem);
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    if (!in_ready || out_valid) begin
      err_proto++;
      $display("after reset in_ready should be high and out_valid low, but they are not");
    end
    run_pass(0);
    run_pass(1);
    @(posedge clk);
    #1;
    out_ready = 1'b1; // any stray result gets taken and flagged by the monitor
    repeat (4) @(posedge clk);
    $display("errors: result %0d, flags %0d, latency %0d, protocol %0d, assertion %0d",
             err_result, err_flags, err_latency, err_proto, i_dut.i_asserts.fail_cnt);
    if (err_result + err_flags + err_latency + err_proto + i_dut.i_asserts.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout: results stopped arriving within %0d cycles", WD_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule
